/* execSlice.f */
+incdir+source
source/rvExecPkg.sv
source/controlUnit.sv
source/immGen.sv
source/regFile.sv
source/aluUnit.sv
source/dataMem.sv
source/execSlice.sv
verification/execSliceTb.sv

/* Bender.yml */
package:
  name: exec_slice

export_include_dirs:
  - source

sources:
  - files:
      - source/rvExecPkg.sv
      - source/controlUnit.sv
      - source/immGen.sv
      - source/regFile.sv
      - source/aluUnit.sv
      - source/dataMem.sv
      - source/execSlice.sv
  - target: test
    files:
      - verification/execSliceTb.sv

/* verification/execSliceTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_defines.svh"

module execSliceTb import rvExecPkg::*; ();

    localparam int RandomCount = 200;
    localparam int DirectedMax = 96;   // Directed offers, rounded up
    localparam int CycleLimit  = 10 + 2 * (DirectedMax + 2 * RandomCount) + 50;
    localparam int MemIdxW     = $clog2(`DMEM_WORDS);
    localparam int DrainCycles = 4;    // Last retire lands one cycle after sampling

    typedef struct packed {
        retireT rec;
        logic   checkResult;           // Write-back value or store data
    } expectT;

    logic             clk = 1'b0;
    logic             rstN;
    instrT            instr;
    logic             instrValid;
    logic             stall;
    logic [`XLEN-1:0] pc;
    retireT           retire;
    logic             retireValid;

    logic [31:0]      lfsrState = 32'd92;
    logic [`XLEN-1:0] modelRegs [`REG_COUNT];
    logic [`XLEN-1:0] modelMem [`DMEM_WORDS];
    logic [`XLEN-1:0] modelPc;
    expectT           expQ [$];
    expectT           expNow;
    int               cycleCount = 0;

    execSlice dut0 (
        .clk,
        .rstN,
        .instr,
        .instrValid,
        .stall,
        .pc,
        .retire,
        .retireValid
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ({1'b0, s[31:1]} ^ 32'hD000_0001) : {1'b0, s[31:1]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};   // One step per bit
        end
        return v;
    endfunction

    function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] storeWord(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] branchWord(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] upperWord(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jalWord(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    // RV32I arithmetic by funct3, alt selects SUB or SRA
    function automatic logic [31:0] computeAlu(input logic [2:0] f3, input logic alt,
        input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'd0, $signed(a) < $signed(b)};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return !($signed(a) < $signed(b));
            3'd6: return a < b;
            default: return !(a < b);
        endcase
    endfunction

    function automatic expectT stepModel(input logic [31:0] w);
        expectT      e;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] addr;
        rd = w[11:7];
        f3 = w[14:12];
        a = modelRegs[w[19:15]];
        b = modelRegs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        e.rec.pc = modelPc;
        e.rec.rd = rd;
        e.rec.regWrite = 1'b1;         // Cleared for branches and stores
        e.rec.result = '0;
        e.rec.nextPc = modelPc + 32'd4;
        case (w[6:0])
            OP:     e.rec.result = computeAlu(f3, w[30], a, b);
            OP_IMM: e.rec.result = computeAlu(f3, w[30] && (f3 == 3'd5), a, immI);
            LUI:    e.rec.result = {w[31:12], 12'd0};
            AUIPC:  e.rec.result = modelPc + {w[31:12], 12'd0};
            JAL: begin
                e.rec.result = modelPc + 32'd4;
                e.rec.nextPc = modelPc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            JALR: begin
                e.rec.result = modelPc + 32'd4;
                e.rec.nextPc = (a + immI) & ~32'd1;
            end
            BRANCH: begin
                e.rec.regWrite = 1'b0;
                if (branchTaken(f3, a, b)) begin
                    e.rec.nextPc = modelPc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            LOAD: begin
                addr = a + immI;
                e.rec.result = modelMem[addr[MemIdxW+1:2]];
            end
            STORE: begin
                addr = a + immS;
                e.rec.regWrite = 1'b0;
                e.rec.result = b;
                modelMem[addr[MemIdxW+1:2]] = b;
            end
            default: e.rec.regWrite = 1'b0;
        endcase
        e.checkResult = e.rec.regWrite || (w[6:0] == STORE);
        if (e.rec.regWrite && (rd != 5'd0)) begin
            modelRegs[rd] = e.rec.result;
        end
        modelPc = e.rec.nextPc;
        return e;
    endfunction

    task automatic reportMismatch(input string field, input logic [31:0] got,
        input logic [31:0] want);
        $display("ERR %0t: %s is %h, expected %h", $time, field, got, want);
        $display("Result: FAILED");
        $fatal(1, "retire check failed");
    endtask

    // A squashed offer is not modelled
    task automatic offer(input logic [31:0] w, input logic withStall);
        @(posedge clk);
        instr <= w;
        instrValid <= 1'b1;
        stall <= withStall;
        if (!withStall) begin
            expQ.push_back(stepModel(w));
        end
    endtask

    task automatic offerRandom();
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic        withStall;
        logic [11:0] offset;
        logic [31:0] w;
        kind = randBits(3);
        rd = randBits(5);
        rs1 = randBits(5);
        rs2 = randBits(5);
        f3 = randBits(3);
        alt = randBits(1);
        withStall = (randBits(3) == 3'd0);  // About one in eight
        case (kind)
            3'd0, 3'd1: begin
                w = rTypeWord((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, alt, 5'd0} : 7'd0,
                              rs2, rs1, f3, rd, OP);
            end
            3'd2: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    // Shift amount taken from rs2 bits
                    w = iTypeWord({1'b0, alt && (f3 == 3'd5), 5'd0, rs2}, rs1, f3, rd, OP_IMM);
                end else begin
                    w = iTypeWord(randBits(12), rs1, f3, rd, OP_IMM);
                end
            end
            3'd3: w = upperWord(randBits(20), rd, alt ? LUI : AUIPC);
            3'd4: begin
                if (alt) begin
                    w = jalWord(randBits(21), rd);
                end else begin
                    w = iTypeWord(randBits(12), rs1, 3'd0, rd, JALR);
                end
            end
            3'd5: w = branchWord(randBits(13), rs2, rs1, (f3[2:1] == 2'b01) ? f3 ^ 3'b110 : f3);
            default: begin
                w = randBits(5);
                offer(iTypeWord({5'd0, w[4:0], 2'd0}, 5'd0, 3'd0, 5'd31, OP_IMM), 1'b0);
                w = randBits(5);
                offset = {5'd0, w[4:0], 2'd0};   // Base plus offset stays below 256
                if (kind == 3'd6) begin
                    w = storeWord(offset, rs2, 5'd31);
                end else begin
                    w = iTypeWord(offset, 5'd31, 3'b010, rd, LOAD);
                end
            end
        endcase
        offer(w, withStall);
    endtask

    always @(negedge clk) begin
        if (rstN && retireValid) begin
            if (expQ.size() == 0) begin
                $display("Spurious retire at %0t with no instruction pending", $time);
                $display("Result: FAILED");
                $fatal(1, "spurious retire");
            end else begin
                expNow = expQ.pop_front();
                assert (retire.pc == expNow.rec.pc)
                    else reportMismatch("retire.pc", retire.pc, expNow.rec.pc);
                assert (retire.regWrite == expNow.rec.regWrite)
                    else reportMismatch("retire.regWrite", retire.regWrite, expNow.rec.regWrite);
                assert (!expNow.rec.regWrite || (retire.rd == expNow.rec.rd))
                    else reportMismatch("retire.rd", retire.rd, expNow.rec.rd);
                assert (!expNow.checkResult || (retire.result == expNow.rec.result))
                    else reportMismatch("retire.result", retire.result, expNow.rec.result);
                assert (retire.nextPc == expNow.rec.nextPc)
                    else reportMismatch("retire.nextPc", retire.nextPc, expNow.rec.nextPc);
                assert (pc == expNow.rec.nextPc)
                    else reportMismatch("pc", pc, expNow.rec.nextPc);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("Timeout: run exceeded %0d cycles", CycleLimit);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rstN <= 1'b0;
        instr <= '0;
        instrValid <= 1'b0;
        stall <= 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            modelMem[i] = '0;
        end
        modelPc = `RESET_PC;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (pc == `RESET_PC) else reportMismatch("pc after reset", pc, `RESET_PC);
        end
        for (int r = 0; r < `REG_COUNT; r++) begin
            offer(rTypeWord(7'd0, 5'd0, r, 3'd0, 5'd0, OP), 1'b0);   // Read xr into x0
        end
        offer(iTypeWord(12'hFFB, 5'd0, 3'd0, 5'd1, OP_IMM), 1'b0);
        offer(iTypeWord(12'd7, 5'd0, 3'd0, 5'd2, OP_IMM), 1'b0);
        for (int f = 0; f < 8; f++) begin
            offer(rTypeWord(7'd0, 5'd2, 5'd1, f, 5'd3, OP), 1'b0);
            offer(iTypeWord((f == 1 || f == 5) ? 12'd3 : 12'hFFD, 5'd1, f, 5'd4, OP_IMM), 1'b0);
        end
        offer(rTypeWord(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OP), 1'b0);    // SUB
        offer(rTypeWord(7'h20, 5'd2, 5'd1, 3'd5, 5'd3, OP), 1'b0);    // SRA
        offer(iTypeWord(12'h403, 5'd1, 3'd5, 5'd4, OP_IMM), 1'b0);    // SRAI
        offer(iTypeWord(12'd123, 5'd1, 3'd0, 5'd0, OP_IMM), 1'b0);
        offer(rTypeWord(7'd0, 5'd0, 5'd0, 3'd0, 5'd3, OP), 1'b0);
        offer(upperWord(20'hABCDE, 5'd5, LUI), 1'b0);
        offer(upperWord(20'h12345, 5'd6, AUIPC), 1'b0);
        offer(jalWord(21'h100, 5'd7), 1'b0);
        offer(iTypeWord(12'h202, 5'd0, 3'd0, 5'd9, OP_IMM), 1'b0);
        offer(iTypeWord(12'd1, 5'd9, 3'd0, 5'd8, JALR), 1'b0);       // Odd target
        offer(iTypeWord(12'hFFF, 5'd0, 3'd0, 5'd10, OP_IMM), 1'b0);
        offer(iTypeWord(12'd1, 5'd0, 3'd0, 5'd11, OP_IMM), 1'b0);
        offer(iTypeWord(12'd1, 5'd0, 3'd0, 5'd12, OP_IMM), 1'b0);
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                offer(branchWord(13'd32, 5'd12, 5'd11, f), 1'b0);    // Equal
                offer(branchWord(13'd32, 5'd11, 5'd10, f), 1'b0);    // Negative vs one
                offer(branchWord(13'd32, 5'd10, 5'd11, f), 1'b0);    // Unsigned large
            end
        end
        offer(iTypeWord(12'd40, 5'd0, 3'd0, 5'd31, OP_IMM), 1'b0);
        offer(iTypeWord(12'h5A5, 5'd0, 3'd0, 5'd13, OP_IMM), 1'b0);
        offer(storeWord(12'd0, 5'd13, 5'd31), 1'b0);
        offer(iTypeWord(12'd0, 5'd31, 3'b010, 5'd14, LOAD), 1'b0);
        offer(iTypeWord(12'd4, 5'd31, 3'b010, 5'd15, LOAD), 1'b0);
        offer(iTypeWord(12'd77, 5'd0, 3'd0, 5'd1, OP_IMM), 1'b1);    // Squashed
        offer(rTypeWord(7'd0, 5'd0, 5'd1, 3'd0, 5'd0, OP), 1'b0);
        repeat (RandomCount) offerRandom();
        @(posedge clk);
        instrValid <= 1'b0;
        stall <= 1'b0;
        for (int i = 0; i < DrainCycles && expQ.size() != 0; i++) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        if (expQ.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Expected retires still pending at end of run");
            $display("Result: FAILED");
            $fatal(1, "missing retires");
        end
    end

endmodule

`default_nettype wire

/* source/execSlice.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_defines.svh"

module execSlice import rvExecPkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  instrT            instr,
    input  logic             instrValid,
    input  logic             stall,
    output logic [`XLEN-1:0] pc,
    output retireT           retire,
    output logic             retireValid
);

    ctrlT             ctrl;
    aluFlagsT         flags;
    logic             commit;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] readData1;
    logic [`XLEN-1:0] readData2;
    logic [`XLEN-1:0] operandA;
    logic [`XLEN-1:0] operandB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] memReadData;
    logic [`XLEN-1:0] writeData;

    // ALU operand selects
    assign operandA = ctrl.aluSrcA ? pc : readData1;
    assign operandB = ctrl.aluSrcB ? imm : readData2;

    controlUnit control0 (
        .clk,
        .rstN,
        .instr,
        .instrValid,
        .stall,
        .flags,
        .imm,
        .aluResult,
        .storeData   (readData2),
        .memReadData,
        .ctrl,
        .commit,
        .pc,
        .writeData,
        .retire,
        .retireValid
    );

    immGen immGen0 (
        .instr,
        .immSrc (ctrl.immSrc),
        .imm
    );

    regFile regFile0 (
        .clk,
        .rstN,
        .rs1         (instr.rType.rs1),
        .rs2         (instr.rType.rs2),
        .rd          (instr.rType.rd),
        .writeData,
        .writeEnable (ctrl.regWrite && commit),
        .readData1,
        .readData2
    );

    aluUnit alu0 (
        .aluOp    (ctrl.aluOp),
        .operandA,
        .operandB,
        .result   (aluResult),
        .flags
    );

    dataMem dataMem0 (
        .clk,
        .rstN,
        .address     (aluResult),
        .writeData   (readData2),
        .writeEnable (ctrl.memWrite && commit),
        .readData    (memReadData)
    );

endmodule

`default_nettype wire

/* source/dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_defines.svh"

module dataMem (
    input  logic             clk,
    input  logic             rstN,
    input  logic [`XLEN-1:0] address,
    input  logic [`XLEN-1:0] writeData,
    input  logic             writeEnable,
    output logic [`XLEN-1:0] readData
);

    localparam int IdxW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] words [`DMEM_WORDS];
    logic [IdxW-1:0]  index;

    assign index = address[IdxW+1:2];   // Upper bits wrap around

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                words[i] <= '0;
            end
        end else if (writeEnable) begin
            words[index] <= writeData;
        end
    end

    assign readData = words[index];

    assert property (@(posedge clk) disable iff (!rstN)
        writeEnable |-> (address[1:0] == 2'b00));

endmodule

`default_nettype wire

/* source/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_defines.svh"

module aluUnit import rvExecPkg::*; (
    input  aluOpT            aluOp,
    input  logic [`XLEN-1:0] operandA,
    input  logic [`XLEN-1:0] operandB,
    output logic [`XLEN-1:0] result,
    output aluFlagsT         flags
);

    logic [`XLEN:0]              diffWide;
    logic [`XLEN-1:0]            diff;
    logic                        overflow;
    logic [$clog2(`XLEN)-1:0]    shamt;

    assign diffWide = {1'b0, operandA} - {1'b0, operandB};
    assign diff     = diffWide[`XLEN-1:0];
    assign shamt    = operandB[$clog2(`XLEN)-1:0];

    // Operands of unlike sign whose difference flips sign
    assign overflow = (operandA[`XLEN-1] != operandB[`XLEN-1])
                   && (diff[`XLEN-1] != operandA[`XLEN-1]);

    assign flags.zero         = (diff == '0);
    assign flags.negative     = diff[`XLEN-1] ^ overflow;
    assign flags.unsignedLess = diffWide[`XLEN];   // Borrow out

    always_comb begin
        case (aluOp)
            ADD:    result = operandA + operandB;
            SUB:    result = diff;
            SLL:    result = operandA << shamt;
            SLT:    result = {{(`XLEN-1){1'b0}}, flags.negative};
            SLTU:   result = {{(`XLEN-1){1'b0}}, flags.unsignedLess};
            XOR:    result = operandA ^ operandB;
            SRL:    result = operandA >> shamt;
            SRA:    result = $signed(operandA) >>> shamt;
            OR:     result = operandA | operandB;
            AND:    result = operandA & operandB;
            PASS_B: result = operandB;              // LUI
            default: result = operandA + operandB;
        endcase
    end

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_defines.svh"

module regFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [$clog2(`REG_COUNT)-1:0] rs1,
    input  logic [$clog2(`REG_COUNT)-1:0] rs2,
    input  logic [$clog2(`REG_COUNT)-1:0] rd,
    input  logic [`XLEN-1:0]              writeData,
    input  logic                          writeEnable,
    output logic [`XLEN-1:0]              readData1,
    output logic [`XLEN-1:0]              readData2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (rd != '0)) begin
            regs[rd] <= writeData;     // x0 never written
        end
    end

    // Read-during-write returns the old value
    assign readData1 = (rs1 == '0) ? '0 : regs[rs1];
    assign readData2 = (rs2 == '0) ? '0 : regs[rs2];

    assert property (@(posedge clk) disable iff (!rstN)
        (rs1 == '0) |-> (readData1 == '0));

endmodule

`default_nettype wire

/* source/immGen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_defines.svh"

module immGen import rvExecPkg::*; (
    input  instrT            instr,
    input  immSrcT           immSrc,
    output logic [`XLEN-1:0] imm
);

    always_comb begin
        case (immSrc)
            IMM_S: begin
                imm = {{(`XLEN-12){instr.sType.immHigh[6]}},
                       instr.sType.immHigh, instr.sType.immLow};
            end
            IMM_B: begin
                // Bit 11 sits in immLow[0], bit 0 is implied
                imm = {{(`XLEN-12){instr.sType.immHigh[6]}},
                       instr.sType.immLow[0], instr.sType.immHigh[5:0],
                       instr.sType.immLow[4:1], 1'b0};
            end
            IMM_U: begin
                imm = {instr.rType.funct7, instr.rType.rs2, instr.rType.rs1,
                       instr.rType.funct3, 12'b0};
            end
            IMM_J: begin
                // Upper bits reuse the rs1 and funct3 fields
                imm = {{(`XLEN-20){instr.iType.imm[11]}},
                       instr.iType.rs1, instr.iType.funct3,
                       instr.iType.imm[0], instr.iType.imm[10:1], 1'b0};
            end
            default: begin
                imm = {{(`XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rvExec_defines.svh"

module controlUnit import rvExecPkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  instrT            instr,
    input  logic             instrValid,
    input  logic             stall,
    input  aluFlagsT         flags,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] aluResult,
    input  logic [`XLEN-1:0] storeData,
    input  logic [`XLEN-1:0] memReadData,
    output ctrlT             ctrl,
    output logic             commit,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] writeData,
    output retireT           retire,
    output logic             retireValid
);

    opcodeT           opcode;
    logic [2:0]       funct3;
    logic             isRType;
    logic             altOp;
    aluOpT            arithOp;
    logic             branchTaken;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcPlusImm;
    logic [`XLEN-1:0] nextPc;

    assign opcode  = instr.rType.opcode;
    assign funct3  = instr.rType.funct3;
    assign isRType = (opcode == OP);
    // SUB, SRA and SRAI all sit on instruction bit 30
    assign altOp   = instr.rType.funct7[5];
    assign commit  = instrValid && !stall;

    always_comb begin
        case (funct3)
            3'b000: arithOp = (isRType && altOp) ? SUB : ADD;
            3'b001: arithOp = SLL;
            3'b010: arithOp = SLT;
            3'b011: arithOp = SLTU;
            3'b100: arithOp = XOR;
            3'b101: arithOp = altOp ? SRA : SRL;
            3'b110: arithOp = OR;
            default: arithOp = AND;
        endcase
    end

    always_comb begin
        ctrl.aluOp     = ADD;          // Safe defaults for unknown opcodes
        ctrl.aluSrcA   = 1'b0;
        ctrl.aluSrcB   = 1'b0;
        ctrl.immSrc    = IMM_I;
        ctrl.resultSrc = RES_ALU;
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        case (opcode)
            OP: begin
                ctrl.aluOp    = arithOp;
                ctrl.regWrite = 1'b1;
            end
            OP_IMM: begin
                ctrl.aluOp    = arithOp;
                ctrl.aluSrcB  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            LOAD: begin
                ctrl.aluSrcB   = 1'b1;
                ctrl.resultSrc = RES_MEM;
                ctrl.regWrite  = 1'b1;
            end
            STORE: begin
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = IMM_S;
                ctrl.memWrite = 1'b1;
            end
            BRANCH: begin
                ctrl.aluOp  = SUB;     // rs1 - rs2 sets the flags
                ctrl.immSrc = IMM_B;
            end
            JAL: begin
                ctrl.aluSrcA   = 1'b1;
                ctrl.aluSrcB   = 1'b1;
                ctrl.immSrc    = IMM_J;
                ctrl.resultSrc = RES_PC4;
                ctrl.regWrite  = 1'b1;
            end
            JALR: begin
                ctrl.aluSrcB   = 1'b1;
                ctrl.resultSrc = RES_PC4;
                ctrl.regWrite  = 1'b1;
            end
            LUI: begin
                ctrl.aluOp    = PASS_B;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = IMM_U;
                ctrl.regWrite = 1'b1;
            end
            AUIPC: begin
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.immSrc   = IMM_U;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
        if (stall) begin
            ctrl.regWrite = 1'b0;      // Squashed, nothing written
            ctrl.memWrite = 1'b0;
        end
    end

    always_comb begin
        case (funct3)
            3'b000: branchTaken = flags.zero;            // BEQ
            3'b001: branchTaken = !flags.zero;           // BNE
            3'b100: branchTaken = flags.negative;        // BLT
            3'b101: branchTaken = !flags.negative;       // BGE
            3'b110: branchTaken = flags.unsignedLess;    // BLTU
            3'b111: branchTaken = !flags.unsignedLess;   // BGEU
            default: branchTaken = 1'b0;
        endcase
    end

    assign pcPlus4   = pc + `XLEN'd4;
    assign pcPlusImm = pc + imm;       // Branch and JAL target adder

    always_comb begin
        case (opcode)
            JAL:     nextPc = pcPlusImm;
            JALR:    nextPc = {aluResult[`XLEN-1:1], 1'b0};
            BRANCH:  nextPc = branchTaken ? pcPlusImm : pcPlus4;
            default: nextPc = pcPlus4;
        endcase
    end

    always_comb begin
        case (ctrl.resultSrc)
            RES_MEM: writeData = memReadData;
            RES_PC4: writeData = pcPlus4;
            default: writeData = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc          <= `RESET_PC;
            retireValid <= 1'b0;
        end else begin
            retireValid <= commit;     // One-cycle strobe per commit
            if (commit) begin
                pc <= nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            retire.pc       <= pc;
            retire.rd       <= instr.rType.rd;
            retire.regWrite <= ctrl.regWrite;
            retire.result   <= ctrl.memWrite ? storeData : writeData;
            retire.nextPc   <= nextPc;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.regWrite && ctrl.memWrite));

    assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> $past(commit));

endmodule

`default_nettype wire

/* source/rvExecPkg.sv */
`default_nettype none

`include "rvExec_defines.svh"

package rvExecPkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } aluOpT;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } resultSrcT;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } immSrcT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHigh;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLow;
        opcodeT     opcode;
    } sTypeT;

    // One instruction word, read through whichever format applies
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
    } instrT;

    typedef struct packed {
        aluOpT     aluOp;
        logic      aluSrcA;    // PC instead of rs1
        logic      aluSrcB;    // Immediate instead of rs2
        immSrcT    immSrc;
        resultSrcT resultSrc;
        logic      regWrite;
        logic      memWrite;
    } ctrlT;

    typedef struct packed {
        logic zero;
        logic negative;        // Signed less, overflow corrected
        logic unsignedLess;
    } aluFlagsT;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [4:0]       rd;
        logic             regWrite;
        logic [`XLEN-1:0] result;   // Store data for SW
        logic [`XLEN-1:0] nextPc;
    } retireT;

endpackage

`default_nettype wire

/* source/rvExec_defines.svh */
`ifndef RVEXEC_DEFINES_SVH
`define RVEXEC_DEFINES_SVH

// Data and address width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// Data memory depth in words, power of two
`define DMEM_WORDS 64

// First PC after reset
`define RESET_PC 32'h0000_0000

`endif
